// ==== sources.f ====
+incdir+hw
hw/uop_pkg.sv
hw/pipe_pkg.sv
hw/issue_slot_if.sv
hw/gpr_array.sv
hw/operand_select.sv
hw/stable_counter.sv
hw/regread_stage.sv
hw/regread_top.sv
tests/regread_tb.sv

// ==== tests/regread_tb.sv ====
// Writes every register before lanes read it; never enables both write ports on one register.
`timescale 1ns/10ps
`include "rf_settings.svh"

module regread_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int RANDOM_CYCLES = 400;

    logic                   clk;
    logic                   reset;
    logic                   stall;
    logic                   flush;
    logic                   write_en_0, write_en_1;
    logic [`RF_AW-1:0]      write_addr_0, write_addr_1;
    logic [`RF_XLEN-1:0]    write_data_0, write_data_1;
    logic                   eu0_en_in, eu1_en_in, eu0_en_out, eu1_en_out;
    logic [`RF_UOPW-1:0]    eu0_uop_in, eu1_uop_in, eu0_uop_out, eu1_uop_out;
    logic [`RF_AW-1:0]      eu0_rd_in, eu1_rd_in, eu0_rd_out, eu1_rd_out;
    logic [`RF_AW-1:0]      eu0_rj_in, eu1_rj_in, eu0_rj_out, eu1_rj_out;
    logic [`RF_AW-1:0]      eu0_rk_in, eu1_rk_in, eu0_rk_out, eu1_rk_out;
    logic [`RF_XLEN-1:0]    eu0_pc_in, eu1_pc_in, eu0_pc_out, eu1_pc_out;
    logic [`RF_XLEN-1:0]    eu0_pc_next_in, eu1_pc_next_in, eu0_pc_next_out, eu1_pc_next_out;
    logic [`RF_EXPW-1:0]    eu0_exp_in, eu1_exp_in, eu0_exp_out, eu1_exp_out;
    logic [`RF_XLEN-1:0]    eu0_imm_in, eu1_imm_in, eu0_imm_out, eu1_imm_out;
    logic [`RF_XLEN-1:0]    read_data00, read_data01, read_data10, read_data11;

    // Reference state.
    logic [`RF_XLEN-1:0]    ref_regs [`RF_NREGS];
    logic [`RF_CNTW-1:0]    ref_count = '0;
    pipe_pkg::lane_t        e_lane [2];
    logic [`RF_XLEN-1:0]    e_opnd [4];
    bit                     armed = 1'b0;
    int                     fail_count = 0;
    int                     seed = 76;

    regread_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // Reference model
    // ============================================================
    function automatic logic [`RF_XLEN-1:0] reg_model(input logic [`RF_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (write_en_0 && (write_addr_0 == addr)) begin
            return write_data_0;
        end
        if (write_en_1 && (write_addr_1 == addr)) begin
            return write_data_1;
        end
        return ref_regs[addr];
    endfunction

    function automatic logic [`RF_XLEN-1:0] expected_operand(
        input int                   lane,
        input bit                   second,
        input logic [`RF_UOPW-1:0]  uop,
        input logic [`RF_AW-1:0]    addr,
        input logic [`RF_XLEN-1:0]  pc,
        input logic [`RF_XLEN-1:0]  imm
    );
        uop_pkg::uop_t          u;
        logic [`RF_XLEN-1:0]    v;
        u = uop;
        v = reg_model(addr);
        if ((lane == 1) || (u.itype == uop_pkg::ITYPE_ALU)) begin
            if (!second) begin
                case (u.src1)
                    uop_pkg::SRC1_PC:    v = pc;
                    uop_pkg::SRC1_ZERO:  v = '0;
                    uop_pkg::SRC1_CNTID: v = '0;
                    default:             v = v;
                endcase
            end else begin
                case (u.src2)
                    uop_pkg::SRC2_IMM:   v = imm;
                    uop_pkg::SRC2_CNTL:  v = ref_count[31:0];
                    uop_pkg::SRC2_CNTH:  v = ref_count[63:32];
                    default:             v = v;
                endcase
            end
        end
        return v;
    endfunction

    // Inputs are read before this edge's drives land.
    always @(posedge clk) begin
        armed = 1'b1;
        if (reset || flush) begin
            e_lane[0] = '0;
            e_lane[1] = '0;
            e_opnd    = '{default: '0};
        end else if (!stall) begin
            e_lane[0] = '{en: eu0_en_in, uop: eu0_uop_in, rd: eu0_rd_in, rj: eu0_rj_in,
                          rk: eu0_rk_in, pc: eu0_pc_in, pc_next: eu0_pc_next_in,
                          exp: eu0_exp_in, imm: eu0_imm_in};
            e_lane[1] = '{en: eu1_en_in, uop: eu1_uop_in, rd: eu1_rd_in, rj: eu1_rj_in,
                          rk: eu1_rk_in, pc: eu1_pc_in, pc_next: eu1_pc_next_in,
                          exp: eu1_exp_in, imm: eu1_imm_in};
            e_opnd[0] = expected_operand(0, 0, eu0_uop_in, eu0_rj_in, eu0_pc_in, eu0_imm_in);
            e_opnd[1] = expected_operand(0, 1, eu0_uop_in, eu0_rk_in, eu0_pc_in, eu0_imm_in);
            e_opnd[2] = expected_operand(1, 0, eu1_uop_in, eu1_rj_in, eu1_pc_in, eu1_imm_in);
            e_opnd[3] = expected_operand(1, 1, eu1_uop_in, eu1_rk_in, eu1_pc_in, eu1_imm_in);
        end
        if (write_en_0) begin
            ref_regs[write_addr_0] = write_data_0;
        end
        if (write_en_1) begin
            ref_regs[write_addr_1] = write_data_1;
        end
        ref_count = reset ? '0 : ref_count + 1'b1;
    end

    // ============================================================
    // Checking
    // ============================================================
    task automatic check(input string name, input logic [63:0] actual, input logic [63:0] expected);
        if (actual !== expected) begin
            fail_count++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    always @(negedge clk) begin
        if (armed) begin
            check("eu0_en_out", eu0_en_out, e_lane[0].en);
            check("eu0_uop_out", eu0_uop_out, e_lane[0].uop);
            check("eu0_rd_out", eu0_rd_out, e_lane[0].rd);
            check("eu0_rj_out", eu0_rj_out, e_lane[0].rj);
            check("eu0_rk_out", eu0_rk_out, e_lane[0].rk);
            check("eu0_pc_out", eu0_pc_out, e_lane[0].pc);
            check("eu0_pc_next_out", eu0_pc_next_out, e_lane[0].pc_next);
            check("eu0_exp_out", eu0_exp_out, e_lane[0].exp);
            check("eu0_imm_out", eu0_imm_out, e_lane[0].imm);
            check("eu1_en_out", eu1_en_out, e_lane[1].en);
            check("eu1_uop_out", eu1_uop_out, e_lane[1].uop);
            check("eu1_rd_out", eu1_rd_out, e_lane[1].rd);
            check("eu1_rj_out", eu1_rj_out, e_lane[1].rj);
            check("eu1_rk_out", eu1_rk_out, e_lane[1].rk);
            check("eu1_pc_out", eu1_pc_out, e_lane[1].pc);
            check("eu1_pc_next_out", eu1_pc_next_out, e_lane[1].pc_next);
            check("eu1_exp_out", eu1_exp_out, e_lane[1].exp);
            check("eu1_imm_out", eu1_imm_out, e_lane[1].imm);
            check("read_data00", read_data00, e_opnd[0]);
            check("read_data01", read_data01, e_opnd[1]);
            check("read_data10", read_data10, e_opnd[2]);
            check("read_data11", read_data11, e_opnd[3]);
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================
    // Type limited to the four defined codes.
    function automatic logic [`RF_UOPW-1:0] random_uop();
        logic [`RF_UOPW-1:0] r;
        r = $random(seed);
        r[`RF_UOPW-1] = 1'b0;
        return r;
    endfunction

    // Favour the write addresses so the bypass gets exercised.
    function automatic logic [`RF_AW-1:0] pick_reg(input logic [`RF_AW-1:0] a0,
                                                   input logic [`RF_AW-1:0] a1);
        int r;
        r = $unsigned($random(seed)) % 4;
        if (r == 0) begin
            return a0;
        end
        if (r == 1) begin
            return a1;
        end
        return $random(seed);
    endfunction

    task automatic drive_random_cycle(input int stall_pct, input int flush_pct);
        logic [`RF_AW-1:0] a0;
        logic [`RF_AW-1:0] a1;
        @(posedge clk);
        a0 = $random(seed);
        a1 = $random(seed);
        stall          <= ($unsigned($random(seed)) % 100) < stall_pct;
        flush          <= ($unsigned($random(seed)) % 100) < flush_pct;
        write_en_0     <= $random(seed);
        write_en_1     <= (a0 == a1) ? 1'b0 : $random(seed);
        write_addr_0   <= a0;
        write_addr_1   <= a1;
        write_data_0   <= $random(seed);
        write_data_1   <= $random(seed);
        eu0_en_in      <= $random(seed);
        eu0_uop_in     <= random_uop();
        eu0_rd_in      <= $random(seed);
        eu0_rj_in      <= pick_reg(a0, a1);
        eu0_rk_in      <= pick_reg(a0, a1);
        eu0_pc_in      <= $random(seed);
        eu0_pc_next_in <= $random(seed);
        eu0_exp_in     <= $random(seed);
        eu0_imm_in     <= $random(seed);
        eu1_en_in      <= $random(seed);
        eu1_uop_in     <= random_uop();
        eu1_rd_in      <= $random(seed);
        eu1_rj_in      <= pick_reg(a0, a1);
        eu1_rk_in      <= pick_reg(a0, a1);
        eu1_pc_in      <= $random(seed);
        eu1_pc_next_in <= $random(seed);
        eu1_exp_in     <= $random(seed);
        eu1_imm_in     <= $random(seed);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("Timeout: reset was still high after 20 cycles");
                $display("CHECKS FAILED");
                $fatal(1, "reset release timeout");
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        {write_en_0, write_addr_0, write_data_0} = '0;
        {write_en_1, write_addr_1, write_data_1} = '0;
        {eu0_en_in, eu0_uop_in, eu0_rd_in, eu0_rj_in, eu0_rk_in} = '0;
        {eu0_pc_in, eu0_pc_next_in, eu0_exp_in, eu0_imm_in} = '0;
        {eu1_en_in, eu1_uop_in, eu1_rd_in, eu1_rj_in, eu1_rk_in} = '0;
        {eu1_pc_in, eu1_pc_next_in, eu1_exp_in, eu1_imm_in} = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait_reset_release();

        // Fill r1..r31 while both lanes read r0.
        for (int i = 1; i < `RF_NREGS; i += 2) begin
            @(posedge clk);
            write_en_0   <= 1'b1;
            write_addr_0 <= i;
            write_data_0 <= $random(seed);
            write_en_1   <= (i + 1 < `RF_NREGS);
            write_addr_1 <= i + 1;
            write_data_1 <= $random(seed);
        end

        repeat (RANDOM_CYCLES) drive_random_cycle(15, 5);

        // Long stall with writes, reads after it, then flush during stall.
        repeat (4) drive_random_cycle(100, 0);
        repeat (3) drive_random_cycle(0, 0);
        drive_random_cycle(100, 100);
        repeat (3) drive_random_cycle(0, 0);

        @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b0;
        repeat (2) @(negedge clk);
        #1;
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "%0d mismatches", fail_count);
        end
    end

endmodule

// ==== hw/regread_top.sv ====
// Flat-port wrapper; caller must not enable both write ports on the same nonzero register.
`timescale 1ns/10ps
`include "rf_settings.svh"

module regread_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    write_en_0,
    input  logic                    write_en_1,
    input  logic [`RF_AW-1:0]       write_addr_0,
    input  logic [`RF_AW-1:0]       write_addr_1,
    input  logic [`RF_XLEN-1:0]     write_data_0,
    input  logic [`RF_XLEN-1:0]     write_data_1,
    input  logic                    eu0_en_in,
    input  logic [`RF_UOPW-1:0]     eu0_uop_in,
    input  logic [`RF_AW-1:0]       eu0_rd_in,
    input  logic [`RF_AW-1:0]       eu0_rj_in,
    input  logic [`RF_AW-1:0]       eu0_rk_in,
    input  logic [`RF_XLEN-1:0]     eu0_pc_in,
    input  logic [`RF_XLEN-1:0]     eu0_pc_next_in,
    input  logic [`RF_EXPW-1:0]     eu0_exp_in,
    input  logic [`RF_XLEN-1:0]     eu0_imm_in,
    input  logic                    eu1_en_in,
    input  logic [`RF_UOPW-1:0]     eu1_uop_in,
    input  logic [`RF_AW-1:0]       eu1_rd_in,
    input  logic [`RF_AW-1:0]       eu1_rj_in,
    input  logic [`RF_AW-1:0]       eu1_rk_in,
    input  logic [`RF_XLEN-1:0]     eu1_pc_in,
    input  logic [`RF_XLEN-1:0]     eu1_pc_next_in,
    input  logic [`RF_EXPW-1:0]     eu1_exp_in,
    input  logic [`RF_XLEN-1:0]     eu1_imm_in,
    output logic                    eu0_en_out,
    output logic [`RF_UOPW-1:0]     eu0_uop_out,
    output logic [`RF_AW-1:0]       eu0_rd_out,
    output logic [`RF_AW-1:0]       eu0_rj_out,
    output logic [`RF_AW-1:0]       eu0_rk_out,
    output logic [`RF_XLEN-1:0]     eu0_pc_out,
    output logic [`RF_XLEN-1:0]     eu0_pc_next_out,
    output logic [`RF_EXPW-1:0]     eu0_exp_out,
    output logic [`RF_XLEN-1:0]     eu0_imm_out,
    output logic                    eu1_en_out,
    output logic [`RF_UOPW-1:0]     eu1_uop_out,
    output logic [`RF_AW-1:0]       eu1_rd_out,
    output logic [`RF_AW-1:0]       eu1_rj_out,
    output logic [`RF_AW-1:0]       eu1_rk_out,
    output logic [`RF_XLEN-1:0]     eu1_pc_out,
    output logic [`RF_XLEN-1:0]     eu1_pc_next_out,
    output logic [`RF_EXPW-1:0]     eu1_exp_out,
    output logic [`RF_XLEN-1:0]     eu1_imm_out,
    output logic [`RF_XLEN-1:0]     read_data00,
    output logic [`RF_XLEN-1:0]     read_data01,
    output logic [`RF_XLEN-1:0]     read_data10,
    output logic [`RF_XLEN-1:0]     read_data11
);

    issue_slot_if lane0_in ();
    issue_slot_if lane1_in ();
    issue_slot_if lane0_out ();
    issue_slot_if lane1_out ();

    pipe_pkg::wr_port_t         wr0;
    pipe_pkg::wr_port_t         wr1;
    logic [`RF_CNTW-1:0]        counter;

    assign wr0 = '{en: write_en_0, addr: write_addr_0, data: write_data_0};
    assign wr1 = '{en: write_en_1, addr: write_addr_1, data: write_data_1};

    // Pack the flat lane inputs.
    assign lane0_in.slot = '{en: eu0_en_in, uop: eu0_uop_in, rd: eu0_rd_in, rj: eu0_rj_in,
                             rk: eu0_rk_in, pc: eu0_pc_in, pc_next: eu0_pc_next_in,
                             exp: eu0_exp_in, imm: eu0_imm_in};
    assign lane1_in.slot = '{en: eu1_en_in, uop: eu1_uop_in, rd: eu1_rd_in, rj: eu1_rj_in,
                             rk: eu1_rk_in, pc: eu1_pc_in, pc_next: eu1_pc_next_in,
                             exp: eu1_exp_in, imm: eu1_imm_in};

    // Unpack the registered lanes.
    assign {eu0_en_out, eu0_uop_out, eu0_rd_out, eu0_rj_out, eu0_rk_out, eu0_pc_out,
            eu0_pc_next_out, eu0_exp_out, eu0_imm_out} = lane0_out.slot;
    assign {eu1_en_out, eu1_uop_out, eu1_rd_out, eu1_rj_out, eu1_rk_out, eu1_pc_out,
            eu1_pc_next_out, eu1_exp_out, eu1_imm_out} = lane1_out.slot;

    stable_counter i_counter (
        .clk   (clk),
        .reset (reset),
        .count (counter)
    );

    regread_stage i_stage (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (flush),
        .wr0         (wr0),
        .wr1         (wr1),
        .counter     (counter),
        .lane0_in    (lane0_in),
        .lane1_in    (lane1_in),
        .lane0_out   (lane0_out),
        .lane1_out   (lane1_out),
        .read_data00 (read_data00),
        .read_data01 (read_data01),
        .read_data10 (read_data10),
        .read_data11 (read_data11)
    );

endmodule

// ==== hw/regread_stage.sv ====
// One-cycle register-read stage; flush beats stall, array writes are never stalled.
`timescale 1ns/10ps
`include "rf_settings.svh"

module regread_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  pipe_pkg::wr_port_t      wr0,
    input  pipe_pkg::wr_port_t      wr1,
    input  logic [`RF_CNTW-1:0]     counter,
    issue_slot_if.dst               lane0_in,
    issue_slot_if.dst               lane1_in,
    issue_slot_if.src               lane0_out,
    issue_slot_if.src               lane1_out,
    output logic [`RF_XLEN-1:0]     read_data00,
    output logic [`RF_XLEN-1:0]     read_data01,
    output logic [`RF_XLEN-1:0]     read_data10,
    output logic [`RF_XLEN-1:0]     read_data11
);

    logic [`RF_AW-1:0]      raddr_j0, raddr_k0, raddr_j1, raddr_k1;
    logic [`RF_XLEN-1:0]    rdata_j0, rdata_k0, rdata_j1, rdata_k1;
    logic [`RF_XLEN-1:0]    opnd_a0, opnd_b0, opnd_a1, opnd_b1;
    pipe_pkg::lane_t        lane0_q;
    pipe_pkg::lane_t        lane1_q;

    // ============================================================
    // Register array and operand selection
    // ============================================================
    gpr_array i_gpr (
        .clk    (clk),
        .wr0    (wr0),
        .wr1    (wr1),
        .raddr0 (raddr_j0),
        .raddr1 (raddr_k0),
        .raddr2 (raddr_j1),
        .raddr3 (raddr_k1),
        .rdata0 (rdata_j0),
        .rdata1 (rdata_k0),
        .rdata2 (rdata_j1),
        .rdata3 (rdata_k1)
    );

    operand_select #(.ALU_ONLY_SELECT(1'b1)) i_sel0 (
        .slot    (lane0_in),
        .wr0     (wr0),
        .wr1     (wr1),
        .rdata_j (rdata_j0),
        .rdata_k (rdata_k0),
        .counter (counter),
        .raddr_j (raddr_j0),
        .raddr_k (raddr_k0),
        .opnd_a  (opnd_a0),
        .opnd_b  (opnd_b0)
    );

    operand_select #(.ALU_ONLY_SELECT(1'b0)) i_sel1 (
        .slot    (lane1_in),
        .wr0     (wr0),
        .wr1     (wr1),
        .rdata_j (rdata_j1),
        .rdata_k (rdata_k1),
        .counter (counter),
        .raddr_j (raddr_j1),
        .raddr_k (raddr_k1),
        .opnd_a  (opnd_a1),
        .opnd_b  (opnd_b1)
    );

    // ============================================================
    // Pipeline register
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            lane0_q     <= '0;
            lane1_q     <= '0;
            read_data00 <= '0;
            read_data01 <= '0;
            read_data10 <= '0;
            read_data11 <= '0;
        end else if (!stall) begin
            lane0_q     <= lane0_in.slot;
            lane1_q     <= lane1_in.slot;
            read_data00 <= opnd_a0;
            read_data01 <= opnd_b0;
            read_data10 <= opnd_a1;
            read_data11 <= opnd_b1;
        end
    end

    assign lane0_out.slot = lane0_q;
    assign lane1_out.slot = lane1_q;

    // A flushed stage must present no valid op downstream.
    a_flush_clears_en: assert property (@(posedge clk) flush |=> !lane0_q.en && !lane1_q.en)
        else $error("lane enable survived a flush");

endmodule

// ==== hw/stable_counter.sv ====
// Free-running up-counter, wraps silently at 2**RF_CNTW.
`timescale 1ns/10ps
`include "rf_settings.svh"

module stable_counter (
    input  logic                    clk,
    input  logic                    reset,
    output logic [`RF_CNTW-1:0]     count
);

    // Zero in the first cycle after reset, then one per edge.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== hw/operand_select.sv ====
// Combinational operand forming; assumes RF_CNTW is twice RF_XLEN, counter-ID source reads zero.
`timescale 1ns/10ps
`include "rf_settings.svh"

module operand_select #(
    parameter bit ALU_ONLY_SELECT = 1'b1
) (
    issue_slot_if.dst               slot,
    input  pipe_pkg::wr_port_t      wr0,
    input  pipe_pkg::wr_port_t      wr1,
    input  logic [`RF_XLEN-1:0]     rdata_j,
    input  logic [`RF_XLEN-1:0]     rdata_k,
    input  logic [`RF_CNTW-1:0]     counter,
    output logic [`RF_AW-1:0]       raddr_j,
    output logic [`RF_AW-1:0]       raddr_k,
    output logic [`RF_XLEN-1:0]     opnd_a,
    output logic [`RF_XLEN-1:0]     opnd_b
);

    uop_pkg::uop_t          uop;
    logic                   apply_sel;
    logic [`RF_XLEN-1:0]    reg_a;
    logic [`RF_XLEN-1:0]    reg_b;

    // Zero register first, then port 0, then port 1, then the array.
    function automatic logic [`RF_XLEN-1:0] reg_value(
        input logic [`RF_AW-1:0]    addr,
        input logic [`RF_XLEN-1:0]  arr,
        input pipe_pkg::wr_port_t   w0,
        input pipe_pkg::wr_port_t   w1
    );
        logic [`RF_XLEN-1:0] v;
        if (addr == '0) begin
            v = '0;
        end else if (w0.en && (w0.addr == addr)) begin
            v = w0.data;
        end else if (w1.en && (w1.addr == addr)) begin
            v = w1.data;
        end else begin
            v = arr;
        end
        return v;
    endfunction

    assign raddr_j = slot.slot.rj;
    assign raddr_k = slot.slot.rk;
    assign uop     = slot.slot.uop;

    // Lane 0 honours the selects only for ALU ops.
    assign apply_sel = !ALU_ONLY_SELECT || (uop.itype == uop_pkg::ITYPE_ALU);

    assign reg_a = reg_value(slot.slot.rj, rdata_j, wr0, wr1);
    assign reg_b = reg_value(slot.slot.rk, rdata_k, wr0, wr1);

    always_comb begin
        opnd_a = reg_a;
        opnd_b = reg_b;
        if (apply_sel) begin
            case (uop.src1)
                uop_pkg::SRC1_PC:    opnd_a = slot.slot.pc;
                uop_pkg::SRC1_ZERO:  opnd_a = '0;
                uop_pkg::SRC1_CNTID: opnd_a = '0;
                default:             opnd_a = reg_a;
            endcase
            case (uop.src2)
                uop_pkg::SRC2_IMM:   opnd_b = slot.slot.imm;
                uop_pkg::SRC2_CNTL:  opnd_b = counter[`RF_XLEN-1:0];
                uop_pkg::SRC2_CNTH:  opnd_b = counter[2*`RF_XLEN-1:`RF_XLEN];
                default:             opnd_b = reg_b;
            endcase
        end
    end

endmodule

// ==== hw/gpr_array.sv ====
// Raw storage only; r0 is stored like any register and bypass is done by the reader.
`timescale 1ns/10ps
`include "rf_settings.svh"

module gpr_array (
    input  logic                    clk,
    input  pipe_pkg::wr_port_t      wr0,
    input  pipe_pkg::wr_port_t      wr1,
    input  logic [`RF_AW-1:0]       raddr0,
    input  logic [`RF_AW-1:0]       raddr1,
    input  logic [`RF_AW-1:0]       raddr2,
    input  logic [`RF_AW-1:0]       raddr3,
    output logic [`RF_XLEN-1:0]     rdata0,
    output logic [`RF_XLEN-1:0]     rdata1,
    output logic [`RF_XLEN-1:0]     rdata2,
    output logic [`RF_XLEN-1:0]     rdata3
);

    logic [`RF_XLEN-1:0] regs [`RF_NREGS];

    // Both writeback ports land on the same edge.
    always_ff @(posedge clk) begin
        if (wr0.en) begin
            regs[wr0.addr] <= wr0.data;
        end
        if (wr1.en) begin
            regs[wr1.addr] <= wr1.data;
        end
    end

    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
    assign rdata3 = regs[raddr3];

    // Array and bypass disagree on which port wins, so a collision is illegal.
    property p_no_write_collision;
        @(posedge clk) !(wr0.en && wr1.en && (wr0.addr == wr1.addr) && (wr0.addr != '0));
    endproperty

    a_no_write_collision: assert property (p_no_write_collision)
        else $error("both write ports target register %0d", wr0.addr);

endmodule

// ==== hw/issue_slot_if.sv ====
// One lane payload per cycle, no handshake; valid is the en field inside the payload.
`timescale 1ns/10ps

interface issue_slot_if;

    // Whole lane payload.
    pipe_pkg::lane_t slot;

    // Driving side.
    modport src (
        output slot
    );

    // Receiving side.
    modport dst (
        input  slot
    );

endinterface

// ==== hw/pipe_pkg.sv ====
// Stage payload types; depends on uop_pkg being compiled first.
`include "rf_settings.svh"

package pipe_pkg;

    // One issue lane as seen by the register-read stage.
    typedef struct packed {
        logic                   en;
        uop_pkg::uop_t          uop;
        logic [`RF_AW-1:0]      rd;
        logic [`RF_AW-1:0]      rj;
        logic [`RF_AW-1:0]      rk;
        logic [`RF_XLEN-1:0]    pc;
        logic [`RF_XLEN-1:0]    pc_next;
        logic [`RF_EXPW-1:0]    exp;
        logic [`RF_XLEN-1:0]    imm;
    } lane_t;

    // One writeback port into the register array.
    typedef struct packed {
        logic                   en;
        logic [`RF_AW-1:0]      addr;
        logic [`RF_XLEN-1:0]    data;
    } wr_port_t;

endpackage

// ==== hw/uop_pkg.sv ====
// Micro-op encoding; only the type and source-select fields are decoded, the rest is opaque.
`include "rf_settings.svh"

package uop_pkg;

    // ============================================================
    // Field encodings
    // ============================================================
    typedef enum logic [2:0] {
        ITYPE_ALU   = 3'd0,
        ITYPE_MEM   = 3'd1,
        ITYPE_BR    = 3'd2,
        ITYPE_OTHER = 3'd3
    } itype_e;

    typedef enum logic [1:0] {
        SRC1_RF    = 2'd0,
        SRC1_PC    = 2'd1,
        SRC1_ZERO  = 2'd2,
        SRC1_CNTID = 2'd3
    } src1_e;

    typedef enum logic [1:0] {
        SRC2_RF   = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_CNTL = 2'd2,
        SRC2_CNTH = 2'd3
    } src2_e;

    // Remainder is passed through the stage unchanged.
    typedef struct packed {
        itype_e                 itype;
        src1_e                  src1;
        src2_e                  src2;
        logic [`RF_UOPW-8:0]    rest;
    } uop_t;

endpackage

// ==== hw/rf_settings.svh ====
// Width settings; the counter must be exactly twice the data width for the low/high selects.
`ifndef RF_SETTINGS_SVH
`define RF_SETTINGS_SVH

// Data word and register file.
`define RF_XLEN  32
`define RF_NREGS 32
`define RF_AW    5

// Exception code carried with each micro-op.
`define RF_EXPW  7

// Free-running time counter.
`define RF_CNTW  64

// Micro-op word, type and select fields in the top bits.
`define RF_UOPW  32

`endif
